//--- flist.f
+incdir+source
+incdir+verification
source/axi3_pkg.sv
source/mem_wr_channel.sv
source/mem_rd_channel.sv
source/axi3_ram_target.sv
source/axi3_mem_subsystem.sv
verification/tb_axi3_mem_subsystem.sv

//--- Makefile
# Verilator simulation of the memory to AXI3 subsystem

VERILATOR ?= verilator
TOP       ?= tb_axi3_mem_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_axi3_vectors.svh
/*
 * Stimulus table for the memory to AXI3 bridge testbench
 * One row per memory access with its expected ack flags and read data
 */
`ifndef TB_AXI3_VECTORS_SVH
`define TB_AXI3_VECTORS_SVH

typedef enum logic {OP_WR, OP_RD} op_t;

// How rd_data is judged on a read row
typedef enum logic [1:0] {CHK_NONE, CHK_EQ, CHK_NE} chk_t;

typedef struct packed {
    op_t                                op;
    logic [`BRIDGE_WORD_ADDR_WID-1:0]   addr;
    logic [`BRIDGE_DATA_BYTES*8-1:0]    data;
    logic                               use_rand;
    logic                               hold;
    logic                               exp_err;
    chk_t                               chk;
    logic [`BRIDGE_DATA_BYTES*8-1:0]    exp_data;
} vec_t;

vec_t vectors [$];

task automatic add_row(input op_t op, input logic [7:0] addr, input logic [31:0] data,
                       input logic use_rand, input logic hold, input logic exp_err,
                       input chk_t chk, input logic [31:0] exp_data);
    vectors.push_back('{op, addr, data, use_rand, hold, exp_err, chk, exp_data});
endtask

task automatic load_vectors();
    // op     word   data           rand  hold  err   check     read data
    add_row(OP_WR, 8'h00, 32'hA5A5_0001, 1'b0, 1'b0, 1'b0, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h00, 32'h0000_0000, 1'b0, 1'b0, 1'b0, CHK_EQ,   32'hA5A5_0001);
    add_row(OP_WR, 8'h5F, 32'h0000_0000, 1'b1, 1'b0, 1'b0, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h5F, 32'h0000_0000, 1'b1, 1'b0, 1'b0, CHK_EQ,   32'h0000_0000);
    add_row(OP_WR, 8'h2A, 32'h0000_0000, 1'b1, 1'b0, 1'b0, CHK_NONE, 32'h0000_0000);
    add_row(OP_WR, 8'h11, 32'h1234_5678, 1'b0, 1'b0, 1'b0, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h2A, 32'h0000_0000, 1'b1, 1'b0, 1'b0, CHK_EQ,   32'h0000_0000);
    add_row(OP_RD, 8'h11, 32'h0000_0000, 1'b0, 1'b0, 1'b0, CHK_EQ,   32'h1234_5678);
    // Protected words keep their content, so the blocked value must not show up
    add_row(OP_RD, 8'h60, 32'h0000_0000, 1'b0, 1'b0, 1'b0, CHK_NONE, 32'h0000_0000);
    add_row(OP_WR, 8'h60, 32'hDEAD_BEEF, 1'b0, 1'b0, 1'b1, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h60, 32'h0000_0000, 1'b0, 1'b0, 1'b0, CHK_NE,   32'hDEAD_BEEF);
    add_row(OP_WR, 8'h7F, 32'h0BAD_F00D, 1'b0, 1'b0, 1'b1, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h7F, 32'h0000_0000, 1'b0, 1'b0, 1'b0, CHK_NE,   32'h0BAD_F00D);
    // Unmapped space times out
    add_row(OP_WR, 8'h80, 32'h1111_1111, 1'b0, 1'b0, 1'b1, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h80, 32'h0000_0000, 1'b0, 1'b0, 1'b1, CHK_EQ,   32'h0000_0000);
    add_row(OP_WR, 8'h05, 32'h2222_3333, 1'b0, 1'b0, 1'b0, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h05, 32'h0000_0000, 1'b0, 1'b0, 1'b0, CHK_EQ,   32'h2222_3333);
    // Requests held through the outstanding one
    add_row(OP_WR, 8'hC8, 32'h4444_5555, 1'b0, 1'b1, 1'b1, CHK_NONE, 32'h0000_0000);
    add_row(OP_WR, 8'h06, 32'h0000_0000, 1'b1, 1'b1, 1'b0, CHK_NONE, 32'h0000_0000);
    add_row(OP_RD, 8'h06, 32'h0000_0000, 1'b1, 1'b1, 1'b0, CHK_EQ,   32'h0000_0000);
    add_row(OP_RD, 8'hFF, 32'h0000_0000, 1'b0, 1'b0, 1'b1, CHK_EQ,   32'h0000_0000);
    add_row(OP_RD, 8'h00, 32'h0000_0000, 1'b0, 1'b0, 1'b0, CHK_EQ,   32'hA5A5_0001);
endtask

`endif

//--- verification/tb_axi3_mem_subsystem.sv
/*
 * Testbench for the memory to AXI3 subsystem
 * Applies the access table and checks acks, error flags, data and latency
 */
`include "axi3_bridge_config.svh"

module tb_axi3_mem_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;
    localparam int ACCEPT_LIMIT = 8;
    localparam int ACK_LIMIT    = `BRIDGE_RD_TIMEOUT + `BRIDGE_WR_TIMEOUT + 8;

    logic                               clk = 1'b0;
    logic                               srst;
    logic                               wr_req;
    logic [`BRIDGE_WORD_ADDR_WID-1:0]   wr_addr;
    logic [`BRIDGE_DATA_BYTES*8-1:0]    wr_data;
    logic                               wr_rdy;
    logic                               wr_ack;
    logic                               wr_err;
    logic                               rd_req;
    logic [`BRIDGE_WORD_ADDR_WID-1:0]   rd_addr;
    logic                               rd_rdy;
    logic                               rd_ack;
    logic                               rd_err;
    logic [`BRIDGE_DATA_BYTES*8-1:0]    rd_data;

    int                                 check_fails = 0;
    int                                 failed_tests = 0;
    int                                 test_count = 0;
    logic                               rows_loaded = 1'b0;
    logic [`BRIDGE_DATA_BYTES*8-1:0]    rand_copy [2**`BRIDGE_WORD_ADDR_WID];

    `include "tb_axi3_vectors.svh"

    axi3_mem_subsystem axi3_mem_subsystem_inst (
        .clk, .srst,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .wr_ack, .wr_err,
        .rd_req, .rd_addr, .rd_rdy, .rd_ack, .rd_err, .rd_data
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s got 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
            check_fails++;
        end
    endtask

    task automatic drive_req(input op_t op, input logic req, input logic [7:0] addr,
                             input logic [31:0] data);
        if (op == OP_RD) begin
            rd_req  = req;
            rd_addr = addr;
        end else begin
            wr_req  = req;
            wr_addr = addr;
            wr_data = data;
        end
    endtask

    // --------------------------------------------------
    // One access, or two back to back when held
    // --------------------------------------------------
    task automatic run_access(input op_t op, input logic [7:0] addr, input logic [31:0] data,
                              input logic hold, input logic exp_err, input chk_t chk,
                              input logic [31:0] exp_data);
        int    waited;
        int    latency;
        int    passes;
        logic  seen;
        string side;
        passes = hold ? 2 : 1;
        side   = (op == OP_RD) ? "rd" : "wr";
        @(posedge clk);
        #1;
        drive_req(op, 1'b1, addr, data);
        for (int p = 0; p < passes; p++) begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < ACCEPT_LIMIT) begin
                @(negedge clk);
                seen = (op == OP_RD) ? rd_rdy : wr_rdy;
                waited++;
            end
            if (!seen) begin
                $display("ERROR at %0t ns: %s request never accepted", $time, side);
                check_fails++;
                drive_req(op, 1'b0, addr, data);
                return;
            end
            // Accepted on this edge
            @(posedge clk);
            #1;
            if (p == passes - 1) begin
                drive_req(op, 1'b0, addr, data);
            end
            latency = 0;
            seen    = 1'b0;
            while (!seen && latency < ACK_LIMIT) begin
                @(negedge clk);
                latency++;
                seen = (op == OP_RD) ? rd_ack : wr_ack;
                if (!seen) begin
                    check_value({side, "_rdy while busy"},
                                32'((op == OP_RD) ? rd_rdy : wr_rdy), 32'd0);
                end
            end
            if (!seen) begin
                $display("ERROR at %0t ns: no %s_ack within %0d cycles", $time, side, ACK_LIMIT);
                check_fails++;
                return;
            end
            // Unmapped words wait out the full timeout
            if (int'(addr) >= `BRIDGE_RAM_WORDS) begin
                check_value({side, "_ack latency"}, 32'(latency),
                            32'(((op == OP_RD) ? `BRIDGE_RD_TIMEOUT : `BRIDGE_WR_TIMEOUT) + 1));
            end else begin
                check_value({side, "_ack latency >= 3"}, 32'(latency >= 3), 32'd1);
            end
            check_value({side, "_err"}, 32'((op == OP_RD) ? rd_err : wr_err), 32'(exp_err));
            if (op == OP_RD && chk == CHK_EQ) begin
                check_value("rd_data", rd_data, exp_data);
            end else if (op == OP_RD && chk == CHK_NE) begin
                check_value("rd_data equal to blocked write", 32'(rd_data === exp_data), 32'd0);
            end
        end
    endtask

    task automatic report_test(input string what, input int fails_before);
        test_count++;
        if (check_fails == fails_before) begin
            $display("[test %0d] %s: ok", test_count, what);
        end else begin
            failed_tests++;
            $display("[test %0d] %s: %0d mismatches", test_count, what,
                     check_fails - fails_before);
        end
    endtask

    // Ends a stuck run
    initial begin
        int limit;
        wait (rows_loaded);
        limit = vectors.size() * (`BRIDGE_RD_TIMEOUT + 20);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int                                 fails_before;
        vec_t                               v;
        logic [`BRIDGE_DATA_BYTES*8-1:0]    wdata_v;
        logic [`BRIDGE_DATA_BYTES*8-1:0]    exp_v;
        string                              what;
        void'($urandom(19));
        srst    = 1'b1;
        wr_req  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_req  = 1'b0;
        rd_addr = '0;
        load_vectors();
        rows_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        srst = 1'b0;

        // Idle after reset
        fails_before = check_fails;
        repeat (3) begin
            @(negedge clk);
            check_value("wr_rdy", 32'(wr_rdy), 32'd1);
            check_value("rd_rdy", 32'(rd_rdy), 32'd1);
            check_value("wr_ack", 32'(wr_ack), 32'd0);
            check_value("rd_ack", 32'(rd_ack), 32'd0);
        end
        report_test("idle after reset", fails_before);

        foreach (vectors[i]) begin
            v            = vectors[i];
            fails_before = check_fails;
            wdata_v      = v.data;
            exp_v        = v.exp_data;
            if (v.use_rand && v.op == OP_WR) begin
                wdata_v           = $urandom;
                rand_copy[v.addr] = wdata_v;
            end else if (v.use_rand) begin
                exp_v = rand_copy[v.addr];
            end
            run_access(v.op, v.addr, wdata_v, v.hold, v.exp_err, v.chk, exp_v);
            what = $sformatf("row %0d %s word 0x%02h%s", i,
                             (v.op == OP_RD) ? "read" : "write", v.addr,
                             v.hold ? " held" : "");
            report_test(what, fails_before);
        end

        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 test_count, failed_tests, check_fails);
        if (check_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_axi3_mem_subsystem

//--- source/axi3_mem_subsystem.sv
/*
 * Memory to AXI3 subsystem
 * Write and read channels bridging the memory ports onto an AXI3 RAM target
 */
`include "axi3_bridge_config.svh"

module axi3_mem_subsystem
    import axi3_pkg::*;
(
    input  logic                                clk,
    input  logic                                srst,
    // Memory write side
    input  logic                                wr_req,
    input  logic [`BRIDGE_WORD_ADDR_WID-1:0]    wr_addr,
    input  logic [`BRIDGE_DATA_BYTES*8-1:0]     wr_data,
    output logic                                wr_rdy,
    output logic                                wr_ack,
    output logic                                wr_err,
    // Memory read side
    input  logic                                rd_req,
    input  logic [`BRIDGE_WORD_ADDR_WID-1:0]    rd_addr,
    output logic                                rd_rdy,
    output logic                                rd_ack,
    output logic                                rd_err,
    output logic [`BRIDGE_DATA_BYTES*8-1:0]     rd_data
);
    // --------------------------------------------------
    // AXI3 bus
    // --------------------------------------------------
    logic                               awvalid;
    logic                               awready;
    logic [`BRIDGE_AXI_ADDR_WID-1:0]    awaddr;
    logic [3:0]                         awlen;
    axsize_t                            awsize;
    axburst_t                           awburst;
    logic                               wvalid;
    logic                               wready;
    logic [`BRIDGE_DATA_BYTES*8-1:0]    wdata;
    logic [`BRIDGE_DATA_BYTES-1:0]      wstrb;
    logic                               wlast;
    logic                               bvalid;
    logic                               bready;
    axresp_t                            bresp;
    logic                               arvalid;
    logic                               arready;
    logic [`BRIDGE_AXI_ADDR_WID-1:0]    araddr;
    logic [3:0]                         arlen;
    axsize_t                            arsize;
    axburst_t                           arburst;
    logic                               rvalid;
    logic                               rready;
    logic [`BRIDGE_DATA_BYTES*8-1:0]    rdata;
    axresp_t                            rresp;
    logic                               rlast;

    mem_wr_channel mem_wr_channel_inst (
        .clk, .srst,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .wr_ack, .wr_err,
        .awvalid, .awready, .awaddr, .awlen, .awsize, .awburst,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .bvalid, .bready, .bresp
    );

    mem_rd_channel mem_rd_channel_inst (
        .clk, .srst,
        .rd_req, .rd_addr, .rd_rdy, .rd_ack, .rd_err, .rd_data,
        .arvalid, .arready, .araddr, .arlen, .arsize, .arburst,
        .rvalid, .rready, .rdata, .rresp, .rlast
    );

    axi3_ram_target axi3_ram_target_inst (
        .clk, .srst,
        .awvalid, .awready, .awaddr, .awlen, .awsize, .awburst,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .arlen, .arsize, .arburst,
        .rvalid, .rready, .rdata, .rresp, .rlast
    );

endmodule : axi3_mem_subsystem

//--- source/axi3_ram_target.sv
/*
 * AXI3 RAM target
 * Single-beat target with a RAM window, a write-protected top region
 * and silent unmapped space above the window
 */
`include "axi3_bridge_config.svh"

module axi3_ram_target
    import axi3_pkg::*;
(
    input  logic                                clk,
    input  logic                                srst,
    // Write address
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [`BRIDGE_AXI_ADDR_WID-1:0]     awaddr,
    input  logic [3:0]                          awlen,
    input  axsize_t                             awsize,
    input  axburst_t                            awburst,
    // Write data
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [`BRIDGE_DATA_BYTES*8-1:0]     wdata,
    input  logic [`BRIDGE_DATA_BYTES-1:0]       wstrb,
    input  logic                                wlast,
    // Write response
    output logic                                bvalid,
    input  logic                                bready,
    output axresp_t                             bresp,
    // Read address
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [`BRIDGE_AXI_ADDR_WID-1:0]     araddr,
    input  logic [3:0]                          arlen,
    input  axsize_t                             arsize,
    input  axburst_t                            arburst,
    // Read data
    output logic                                rvalid,
    input  logic                                rready,
    output logic [`BRIDGE_DATA_BYTES*8-1:0]     rdata,
    output axresp_t                             rresp,
    output logic                                rlast
);
    localparam int DATA_BYTES   = `BRIDGE_DATA_BYTES;
    localparam int ADDR_WID     = `BRIDGE_AXI_ADDR_WID;
    localparam int BYTE_SEL_WID = $clog2(DATA_BYTES);
    localparam int IDX_WID      = $clog2(`BRIDGE_RAM_WORDS);
    localparam logic [ADDR_WID-1:0] BASE      = ADDR_WID'(`BRIDGE_BASE_ADDR);
    localparam logic [ADDR_WID-1:0] WIN_BYTES = ADDR_WID'(`BRIDGE_RAM_WORDS * DATA_BYTES);
    localparam axsize_t WORD_SIZE = get_axsize(DATA_BYTES);

    logic [DATA_BYTES*8-1:0]    mem [`BRIDGE_RAM_WORDS];

    logic [ADDR_WID-1:0]        wr_off;
    logic [ADDR_WID-1:0]        rd_off;
    logic [IDX_WID-1:0]         wr_idx;
    logic [IDX_WID-1:0]         rd_idx;
    logic                       wr_mapped;
    logic                       rd_mapped;
    logic                       wr_prot;
    logic                       wr_accept;
    logic                       rd_accept;

    // --------------------------------------------------
    // Window decode
    // --------------------------------------------------
    assign wr_off    = awaddr - BASE;
    assign rd_off    = araddr - BASE;
    assign wr_mapped = (awaddr >= BASE) && (wr_off < WIN_BYTES);
    assign rd_mapped = (araddr >= BASE) && (rd_off < WIN_BYTES);
    assign wr_idx    = wr_off[BYTE_SEL_WID +: IDX_WID];
    assign rd_idx    = rd_off[BYTE_SEL_WID +: IDX_WID];
    assign wr_prot   = (int'(wr_idx) >= `BRIDGE_WP_START);

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    // AW and W taken together while no B is pending
    assign awready   = wvalid && !bvalid;
    assign wready    = awvalid && !bvalid;
    assign wr_accept = awvalid && wvalid && !bvalid;

    always_ff @(posedge clk) begin
        if (srst) bvalid <= 1'b0;
        else if (wr_accept && wr_mapped) bvalid <= 1'b1;
        else if (bready) bvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (wr_accept) bresp <= wr_prot ? RESP_SLVERR : RESP_OKAY;
    end

    // Per-byte write, protected words left unchanged
    always_ff @(posedge clk) begin
        if (wr_accept && wr_mapped && !wr_prot) begin
            for (int i = 0; i < DATA_BYTES; i++) begin
                if (wstrb[i]) mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    assign arready   = !rvalid;
    assign rd_accept = arvalid && arready;

    always_ff @(posedge clk) begin
        if (srst) rvalid <= 1'b0;
        else if (rd_accept && rd_mapped) rvalid <= 1'b1;
        else if (rready) rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_accept) rdata <= mem[rd_idx];
    end

    assign rresp = RESP_OKAY;
    assign rlast = rvalid;

    // Only single-beat word transfers reach this target
    assert property (@(posedge clk) disable iff (srst)
        wr_accept |-> awlen == '0 && wlast && awsize == WORD_SIZE && awburst == BURST_INCR);

    assert property (@(posedge clk) disable iff (srst)
        rd_accept |-> arlen == '0 && arsize == WORD_SIZE && arburst == BURST_INCR);

endmodule : axi3_ram_target

//--- source/mem_rd_channel.sv
/*
 * Memory read channel
 * Turns each accepted word read into one single-beat AXI3 read and
 * returns the data, or zero with an error on timeout
 */
`include "axi3_bridge_config.svh"

module mem_rd_channel
    import axi3_pkg::*;
(
    input  logic                                clk,
    input  logic                                srst,
    // Memory read side
    input  logic                                rd_req,
    input  logic [`BRIDGE_WORD_ADDR_WID-1:0]    rd_addr,
    output logic                                rd_rdy,
    output logic                                rd_ack,
    output logic                                rd_err,
    output logic [`BRIDGE_DATA_BYTES*8-1:0]     rd_data,
    // AXI3 read address
    output logic                                arvalid,
    input  logic                                arready,
    output logic [`BRIDGE_AXI_ADDR_WID-1:0]     araddr,
    output logic [3:0]                          arlen,
    output axsize_t                             arsize,
    output axburst_t                            arburst,
    // AXI3 read data
    input  logic                                rvalid,
    output logic                                rready,
    input  logic [`BRIDGE_DATA_BYTES*8-1:0]     rdata,
    input  axresp_t                             rresp,
    input  logic                                rlast
);
    localparam int AXI_ADDR_WID = `BRIDGE_AXI_ADDR_WID;
    localparam int BYTE_SEL_WID = $clog2(`BRIDGE_DATA_BYTES);
    localparam int TIMER_WID    = $clog2(`BRIDGE_RD_TIMEOUT + 1);
    localparam logic [AXI_ADDR_WID-1:0] AXI_BASE = AXI_ADDR_WID'(`BRIDGE_BASE_ADDR);

    chan_state_t            state;
    logic [TIMER_WID-1:0]   timer;
    logic                   accept;
    logic                   busy;
    logic                   timeout;
    logic                   r_hs;
    logic                   finish;

    assign accept  = rd_req && rd_rdy;
    assign busy    = (state == ST_ISSUE) || (state == ST_WAIT_RESP);
    assign timeout = busy && (timer == TIMER_WID'(`BRIDGE_RD_TIMEOUT - 1));
    assign r_hs    = rvalid && rready;
    assign finish  = r_hs || timeout;

    // --------------------------------------------------
    // Request capture and FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (accept) state <= ST_ISSUE;
                ST_ISSUE: begin
                    if (finish) state <= ST_DONE;
                    else if (!arvalid) state <= ST_WAIT_RESP;
                end
                ST_WAIT_RESP: if (finish) state <= ST_DONE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (srst || !busy) timer <= '0;
        else timer <= timer + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (accept) araddr <= AXI_BASE + (AXI_ADDR_WID'(rd_addr) << BYTE_SEL_WID);
    end

    always_ff @(posedge clk) begin
        if (srst) arvalid <= 1'b0;
        else if (accept) arvalid <= 1'b1;
        else if (arready || timeout) arvalid <= 1'b0;
    end

    assign arlen   = '0;
    assign arsize  = get_axsize(`BRIDGE_DATA_BYTES);
    assign arburst = BURST_INCR;

    // --------------------------------------------------
    // Data return
    // --------------------------------------------------
    assign rready = busy;

    // Zero-fill on timeout
    always_ff @(posedge clk) begin
        if (r_hs) begin
            rd_data <= rdata;
            rd_err  <= (rresp != RESP_OKAY);
        end else if (timeout) begin
            rd_data <= '0;
            rd_err  <= 1'b1;
        end
    end

    assign rd_rdy = (state == ST_IDLE);
    assign rd_ack = (state == ST_DONE);

    assert property (@(posedge clk) disable iff (srst)
        arvalid && !arready && !timeout |=> arvalid && $stable(araddr));

    // Target must close every single-beat read
    assert property (@(posedge clk) disable iff (srst) r_hs |-> rlast);

endmodule : mem_rd_channel

//--- source/mem_wr_channel.sv
/*
 * Memory write channel
 * Turns each accepted word write into one single-beat AXI3 write and
 * acks on the B response, or on timeout with an error
 */
`include "axi3_bridge_config.svh"

module mem_wr_channel
    import axi3_pkg::*;
(
    input  logic                                clk,
    input  logic                                srst,
    // Memory write side
    input  logic                                wr_req,
    input  logic [`BRIDGE_WORD_ADDR_WID-1:0]    wr_addr,
    input  logic [`BRIDGE_DATA_BYTES*8-1:0]     wr_data,
    output logic                                wr_rdy,
    output logic                                wr_ack,
    output logic                                wr_err,
    // AXI3 write address
    output logic                                awvalid,
    input  logic                                awready,
    output logic [`BRIDGE_AXI_ADDR_WID-1:0]     awaddr,
    output logic [3:0]                          awlen,
    output axsize_t                             awsize,
    output axburst_t                            awburst,
    // AXI3 write data
    output logic                                wvalid,
    input  logic                                wready,
    output logic [`BRIDGE_DATA_BYTES*8-1:0]     wdata,
    output logic [`BRIDGE_DATA_BYTES-1:0]       wstrb,
    output logic                                wlast,
    // AXI3 write response
    input  logic                                bvalid,
    output logic                                bready,
    input  axresp_t                             bresp
);
    localparam int AXI_ADDR_WID = `BRIDGE_AXI_ADDR_WID;
    localparam int BYTE_SEL_WID = $clog2(`BRIDGE_DATA_BYTES);
    localparam int TIMER_WID    = $clog2(`BRIDGE_WR_TIMEOUT + 1);
    localparam logic [AXI_ADDR_WID-1:0] AXI_BASE = AXI_ADDR_WID'(`BRIDGE_BASE_ADDR);

    chan_state_t            state;
    logic [TIMER_WID-1:0]   timer;
    logic                   accept;
    logic                   busy;
    logic                   timeout;
    logic                   b_hs;
    logic                   finish;

    assign accept  = wr_req && wr_rdy;
    assign busy    = (state == ST_ISSUE) || (state == ST_WAIT_RESP);
    assign timeout = busy && (timer == TIMER_WID'(`BRIDGE_WR_TIMEOUT - 1));
    assign b_hs    = bvalid && bready;
    assign finish  = b_hs || timeout;

    // --------------------------------------------------
    // Request capture and FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (accept) state <= ST_ISSUE;
                ST_ISSUE: begin
                    if (finish) state <= ST_DONE;
                    else if (!awvalid && !wvalid) state <= ST_WAIT_RESP;
                end
                ST_WAIT_RESP: if (finish) state <= ST_DONE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Counts cycles since acceptance
    always_ff @(posedge clk) begin
        if (srst || !busy) timer <= '0;
        else timer <= timer + 1'b1;
    end

    // Byte address from base plus shifted word address
    always_ff @(posedge clk) begin
        if (accept) begin
            awaddr <= AXI_BASE + (AXI_ADDR_WID'(wr_addr) << BYTE_SEL_WID);
            wdata  <= wr_data;
        end
    end

    // AW and W each drop after their own handshake
    always_ff @(posedge clk) begin
        if (srst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (accept) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            if (awready || timeout) awvalid <= 1'b0;
            if (wready || timeout) wvalid <= 1'b0;
        end
    end

    // Single-beat metadata
    assign awlen   = '0;
    assign awsize  = get_axsize(`BRIDGE_DATA_BYTES);
    assign awburst = BURST_INCR;
    assign wstrb   = '1;
    assign wlast   = 1'b1;

    // --------------------------------------------------
    // Response and ack
    // --------------------------------------------------
    assign bready = busy;

    always_ff @(posedge clk) begin
        if (b_hs) wr_err <= (bresp != RESP_OKAY);
        else if (timeout) wr_err <= 1'b1;
    end

    assign wr_rdy = (state == ST_IDLE);
    assign wr_ack = (state == ST_DONE);

    // AW payload holds until accepted or withdrawn
    assert property (@(posedge clk) disable iff (srst)
        awvalid && !awready && !timeout |=> awvalid && $stable(awaddr));

    assert property (@(posedge clk) disable iff (srst) wr_ack |=> !wr_ack);

endmodule : mem_wr_channel

//--- source/axi3_pkg.sv
/*
 * AXI3 types for the memory bridge
 * Size, burst and response encodings plus the channel FSM states
 */
package axi3_pkg;

    // Bytes per beat, as log2
    typedef enum logic [2:0] {
        SIZE_1BYTE    = 3'd0,
        SIZE_2BYTES   = 3'd1,
        SIZE_4BYTES   = 3'd2,
        SIZE_8BYTES   = 3'd3,
        SIZE_16BYTES  = 3'd4,
        SIZE_32BYTES  = 3'd5,
        SIZE_64BYTES  = 3'd6,
        SIZE_128BYTES = 3'd7
    } axsize_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axburst_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axresp_t;

    // Shared by the read and write channels
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_RESP,
        ST_DONE
    } chan_state_t;

    // Byte count must be a power of two
    function automatic axsize_t get_axsize(input int bytes);
        return axsize_t'($clog2(bytes));
    endfunction

endpackage : axi3_pkg

//--- source/axi3_bridge_config.svh
/*
 * Memory to AXI3 bridge configuration
 * Word geometry, address map of the target RAM and channel timeouts
 */
`ifndef AXI3_BRIDGE_CONFIG_SVH
`define AXI3_BRIDGE_CONFIG_SVH

// Word geometry
`define BRIDGE_DATA_BYTES      4
`define BRIDGE_WORD_ADDR_WID   8

// AXI side address map
`define BRIDGE_AXI_ADDR_WID    16
`define BRIDGE_BASE_ADDR       4096
`define BRIDGE_RAM_WORDS       128
// Words from here up to the end of the window are write-protected
`define BRIDGE_WP_START        96

// Cycles from acceptance before a forced ack
`define BRIDGE_WR_TIMEOUT      32
`define BRIDGE_RD_TIMEOUT      32

`endif
